//--- hw/tiny16_pkg.sv
`default_nettype none

package tiny16_pkg;

    // ========================================
    // widths
    // ========================================

    // program space is 8k bytes.
    localparam int pc_bits = 13;

    // ========================================
    // alu op codes
    // ========================================

    localparam logic [4:0] op_clr  = 5'd0;
    localparam logic [4:0] op_set  = 5'd1;
    localparam logic [4:0] op_inc  = 5'd2;
    localparam logic [4:0] op_dec  = 5'd3;
    localparam logic [4:0] op_not  = 5'd4;
    localparam logic [4:0] op_neg  = 5'd5;
    localparam logic [4:0] op_shl  = 5'd6;
    localparam logic [4:0] op_shr  = 5'd7;
    localparam logic [4:0] op_rol  = 5'd8;
    localparam logic [4:0] op_ror  = 5'd9;

    localparam logic [4:0] op_mov  = 5'd16;
    localparam logic [4:0] op_adc  = 5'd17;
    localparam logic [4:0] op_add  = 5'd18;
    localparam logic [4:0] op_sbc  = 5'd19;
    localparam logic [4:0] op_sub  = 5'd20;
    localparam logic [4:0] op_and  = 5'd21;
    localparam logic [4:0] op_or   = 5'd22;
    localparam logic [4:0] op_xor  = 5'd23;

    localparam logic [4:0] op_cmp  = 5'd30;
    localparam logic [4:0] op_test = 5'd31;

    // condition select bits in the branch view.
    localparam int cond_c = 2;
    localparam int cond_z = 1;
    localparam int cond_n = 0;

    // ========================================
    // instruction and data types
    // ========================================

    // the op field fills bits 4:0, so imm8 and imm16 take bits 5 and 6.
    typedef struct packed {
        logic       kind;
        logic       imm16;
        logic       imm8;
        logic [4:0] op;
    } alu_view_t;

    typedef struct packed {
        logic       kind;
        logic [2:0] unused;
        logic       neg;
        logic [2:0] cond;
    } branch_view_t;

    // kind is 0 for an alu instruction and 1 for a branch.
    typedef union packed {
        alu_view_t    alu;
        branch_view_t br;
    } tiny16_instr_u;

    typedef struct packed {
        tiny16_instr_u instr;
        logic [15:0]   reg_a;
        logic [15:0]   reg_b;
        logic [15:0]   imm;
    } exec_in_t;

    typedef struct packed {
        logic [15:0]        acc;
        logic               c;
        logic [pc_bits-1:0] pc;
    } exec_state_t;

    typedef struct packed {
        logic c;
        logic z;
        logic n;
    } flags_t;

endpackage

`default_nettype wire

//--- hw/tiny16_alu.sv
`default_nettype none

module tiny16_alu (
    input  tiny16_pkg::exec_in_t    in_data,
    input  tiny16_pkg::exec_state_t cur,
    output tiny16_pkg::exec_state_t alu_res
);
    import tiny16_pkg::*;

    tiny16_instr_u instr;
    logic [4:0]    op;
    logic [15:0]   a;
    logic [15:0]   b;
    logic          cin;
    logic [16:0]   sum;
    logic [16:0]   diff;
    logic [15:0]   acc_next;
    logic          c_next;

    assign instr = in_data.instr;
    assign op = instr.alu.op;
    assign a = in_data.reg_a;

    // ========================================
    // second operand
    // ========================================

    // the 8-bit immediate is the low byte of imm and is sign extended.
    always_comb begin
        if (instr.alu.imm8) begin
            b = {{8{in_data.imm[7]}}, in_data.imm[7:0]};
        end else if (instr.alu.imm16) begin
            b = in_data.imm;
        end else begin
            b = in_data.reg_b;
        end
    end

    // ========================================
    // adder and subtractor
    // ========================================

    // carry in only for adc and sbc.
    assign cin = ((op == op_adc) || (op == op_sbc)) ? cur.c : 1'b0;

    assign sum = {1'b0, a} + {1'b0, b} + {16'h0000, cin};

    // bit 16 of the difference is the borrow.
    assign diff = {1'b0, a} - {1'b0, b} - {16'h0000, cin};

    // ========================================
    // result select
    // ========================================

    always_comb begin
        acc_next = cur.acc;
        c_next = cur.c;
        case (op)
            op_clr: acc_next = 16'h0000;
            op_set: acc_next = 16'hffff;
            op_inc: acc_next = a + 16'd1;
            op_dec: acc_next = a - 16'd1;
            op_not: acc_next = ~a;
            op_neg: acc_next = -a;
            op_shl: begin
                acc_next = {a[14:0], 1'b0};
                c_next = a[15];
            end
            op_shr: begin
                acc_next = {1'b0, a[15:1]};
                c_next = a[0];
            end
            // rotates go through the carry.
            op_rol: begin
                acc_next = {a[14:0], cur.c};
                c_next = a[15];
            end
            op_ror: begin
                acc_next = {cur.c, a[15:1]};
                c_next = a[0];
            end
            op_mov: acc_next = b;
            op_adc, op_add: begin
                acc_next = sum[15:0];
                c_next = sum[16];
            end
            op_sbc, op_sub, op_cmp: begin
                acc_next = diff[15:0];
                c_next = diff[16];
            end
            op_and, op_test: acc_next = a & b;
            op_or: acc_next = a | b;
            op_xor: acc_next = a ^ b;
            default: begin
                acc_next = cur.acc;
                c_next = cur.c;
            end
        endcase
    end

    assign alu_res.acc = acc_next;
    assign alu_res.c = c_next;
    // pc is owned by the branch unit.
    assign alu_res.pc = '0;

endmodule

`default_nettype wire

//--- hw/tiny16_branch.sv
`default_nettype none

module tiny16_branch (
    input  tiny16_pkg::tiny16_instr_u       instr,
    input  logic [7:0]                      offset,
    input  tiny16_pkg::flags_t              flags,
    input  logic [tiny16_pkg::pc_bits-1:0]  pc,
    output logic [tiny16_pkg::pc_bits-1:0]  next_pc
);
    import tiny16_pkg::*;

    logic [2:0]         flag_vec;
    logic [2:0]         selected;
    logic               cond_pass;
    logic               taken;
    logic [pc_bits-1:0] offset_ext;

    // the vector uses the bit order of the cond field.
    always_comb begin
        flag_vec[cond_c] = flags.c;
        flag_vec[cond_z] = flags.z;
        flag_vec[cond_n] = flags.n;
    end

    assign selected = instr.br.cond & flag_vec;

    // an empty cond with neg set is an unconditional branch.
    assign cond_pass = (|selected) ^ instr.br.neg;

    assign taken = instr.br.kind & cond_pass;

    assign offset_ext = {{(pc_bits - 8){offset[7]}}, offset};

    // the pc wraps at 2**pc_bits.
    always_comb begin
        if (taken) begin
            next_pc = pc + offset_ext;
        end else begin
            next_pc = pc + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hw/tiny16_commit.sv
`default_nettype none

module tiny16_commit (
    input  logic                            clk,
    input  logic                            nreset,
    input  logic                            in_valid,
    input  logic                            is_branch,
    input  tiny16_pkg::exec_state_t         alu_res,
    input  logic [tiny16_pkg::pc_bits-1:0]  next_pc,
    output tiny16_pkg::exec_state_t         cur,
    output tiny16_pkg::flags_t              flags,
    output logic                            out_valid
);
    import tiny16_pkg::*;

    // ========================================
    // architectural state
    // ========================================

    always_ff @(posedge clk) begin
        if (!nreset) begin
            cur <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin
                // branches leave acc and c alone.
                if (!is_branch) begin
                    cur.acc <= alu_res.acc;
                    cur.c <= alu_res.c;
                end
                cur.pc <= next_pc;
            end
        end
    end

    // z and n follow the committed accumulator.
    assign flags = flags_t'{c: cur.c, z: (cur.acc == 16'h0000), n: cur.acc[15]};

    // ========================================
    // assertions
    // ========================================

    // a result is only reported for an instruction taken one cycle earlier.
    out_valid_follows_in: assert property (
        @(posedge clk) disable iff (!nreset)
        out_valid |-> $past(in_valid)
    );

    // without a strobe the state holds.
    state_holds_when_idle: assert property (
        @(posedge clk) disable iff (!nreset)
        !in_valid |=> $stable(cur)
    );

    state_known: assert property (
        @(posedge clk) disable iff (!nreset)
        !$isunknown({cur, out_valid})
    );

endmodule

`default_nettype wire

//--- hw/tiny16_exec.sv
`default_nettype none

module tiny16_exec (
    input  logic                    clk,
    input  logic                    nreset,
    input  logic                    in_valid,
    input  tiny16_pkg::exec_in_t    in_data,
    output logic                    out_valid,
    output tiny16_pkg::exec_state_t state
);
    import tiny16_pkg::*;

    exec_state_t        cur;
    exec_state_t        alu_res;
    flags_t             flags;
    logic [pc_bits-1:0] next_pc;

    tiny16_alu alu (
        .in_data (in_data),
        .cur     (cur),
        .alu_res (alu_res)
    );

    // the low immediate byte doubles as the branch offset.
    tiny16_branch branch (
        .instr   (in_data.instr),
        .offset  (in_data.imm[7:0]),
        .flags   (flags),
        .pc      (cur.pc),
        .next_pc (next_pc)
    );

    tiny16_commit commit (
        .clk       (clk),
        .nreset    (nreset),
        .in_valid  (in_valid),
        .is_branch (in_data.instr.br.kind),
        .alu_res   (alu_res),
        .next_pc   (next_pc),
        .cur       (cur),
        .flags     (flags),
        .out_valid (out_valid)
    );

    assign state = cur;

endmodule

`default_nettype wire

//--- verif/tb_clock.sv
`default_nettype none

module tb_clock (
    output logic clk,
    output logic nreset
);

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // reset is released just after the second rising edge.
    initial begin
        nreset = 1'b0;
        repeat (2) @(posedge clk);
        #1 nreset = 1'b1;
    end

endmodule

`default_nettype wire

//--- verif/tiny16_exec_tb.sv
`default_nettype none

module tiny16_exec_tb;
    import tiny16_pkg::*;

    // the worst case covers reset, 300 strobes with gaps up to 3, 200 back to back,
    // 200 branches behind up to 2 alu instructions, 50 idle cycles and the drains.
    localparam int max_cycles = 2 + 5 + 300 * 4 + 1 + 201 + 200 * 3 + 1 + 50 + 1;
    localparam int timeout_time = max_cycles * 10 + 500;

    logic        clk;
    logic        nreset;
    logic        in_valid;
    exec_in_t    in_data;
    logic        out_valid;
    exec_state_t state;

    logic [15:0]        model_acc = '0;
    logic               model_c = 1'b0;
    logic [pc_bits-1:0] model_pc = '0;
    logic               expect_valid = 1'b0;
    int                 checks = 0;
    int                 errors = 0;
    int                 test_errors = 0;

    tb_clock clock_gen (.clk(clk), .nreset(nreset));

    tiny16_exec UUT (
        .clk       (clk),
        .nreset    (nreset),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .out_valid (out_valid),
        .state     (state)
    );

    // ========================================
    // reference model
    // ========================================

    task automatic apply_model(input exec_in_t d);
        logic [15:0] a;
        logic [15:0] b;
        logic        c_old;
        logic [2:0]  flag_bits;
        int          cin;
        int          wide;
        int          target;
        a = d.reg_a;
        c_old = model_c;
        flag_bits = {model_c, model_acc == 16'h0000, model_acc[15]};
        b = d.instr.alu.imm8 ? {{8{d.imm[7]}}, d.imm[7:0]} :
            (d.instr.alu.imm16 ? d.imm : d.reg_b);
        cin = (d.instr.alu.op == op_adc || d.instr.alu.op == op_sbc) ? int'(c_old) : 0;
        target = int'(model_pc) + 1;
        if (d.instr.br.kind) begin
            if (((d.instr.br.cond & flag_bits) != 3'b000) != d.instr.br.neg) begin
                target = int'(model_pc) + int'($signed(d.imm[7:0]));
            end
        end else begin
            case (d.instr.alu.op)
                op_clr: model_acc = 16'h0000;
                op_set: model_acc = 16'hffff;
                op_inc: model_acc = a + 16'd1;
                op_dec: model_acc = a - 16'd1;
                op_not: model_acc = ~a;
                op_neg: model_acc = 16'd0 - a;
                op_shl: {model_c, model_acc} = {a, 1'b0};
                op_shr: {model_acc, model_c} = {1'b0, a};
                op_rol: {model_c, model_acc} = {a, c_old};
                op_ror: {model_acc, model_c} = {c_old, a};
                op_mov: model_acc = b;
                op_add, op_adc: begin
                    wide = int'(a) + int'(b) + cin;
                    model_acc = wide[15:0];
                    model_c = wide > 65535;
                end
                op_sub, op_sbc, op_cmp: begin
                    model_acc = a - b - 16'(cin);
                    model_c = int'(a) < int'(b) + cin;
                end
                op_and, op_test: model_acc = a & b;
                op_or: model_acc = a | b;
                op_xor: model_acc = a ^ b;
                default: ;
            endcase
        end
        // the pc wraps at 2**pc_bits.
        model_pc = target[pc_bits-1:0];
    endtask

    // ========================================
    // stimulus and checks
    // ========================================

    function automatic exec_in_t random_alu();
        exec_in_t d;
        d.reg_a = 16'($urandom());
        d.reg_b = 16'($urandom());
        d.imm = 16'($urandom());
        // a zero operand now and then drives the z flag.
        if ($urandom_range(7, 0) == 0) begin
            d.reg_a = 16'h0000;
        end
        d.instr.alu.kind = 1'b0;
        d.instr.alu.imm16 = 1'($urandom_range(1, 0));
        d.instr.alu.imm8 = 1'($urandom_range(1, 0));
        d.instr.alu.op = 5'($urandom_range(31, 0));
        return d;
    endfunction

    function automatic exec_in_t random_branch();
        exec_in_t d;
        d.reg_a = 16'($urandom());
        d.reg_b = 16'($urandom());
        d.imm = 16'($urandom());
        // mostly negative offsets, so the pc walks down through zero and wraps.
        if ($urandom_range(3, 0) != 0) begin
            d.imm[7] = 1'b1;
        end
        d.instr.br.kind = 1'b1;
        d.instr.br.unused = 3'($urandom_range(7, 0));
        d.instr.br.neg = 1'($urandom_range(1, 0));
        d.instr.br.cond = 3'($urandom_range(7, 0));
        return d;
    endfunction

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] want);
        checks++;
        assert (got === want) else begin
            $display("mismatch %s: got %h expected %h at time %0t", name, got, want, $time);
            errors++;
            test_errors++;
        end
    endtask

    // outputs are registered, so they are stable one unit after the edge.
    task automatic cycle(input logic valid, input exec_in_t d);
        @(posedge clk);
        #1;
        check_value("out_valid", 16'(out_valid), 16'(expect_valid));
        check_value("acc", state.acc, model_acc);
        check_value("c", 16'(state.c), 16'(model_c));
        check_value("pc", 16'(state.pc), 16'(model_pc));
        in_valid = valid;
        in_data = d;
        expect_valid = valid;
        if (valid) begin
            apply_model(d);
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %s done: %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    initial begin
        void'($urandom(32'hf3fa10f6));
        in_valid = 1'b0;
        in_data = '0;
        wait (nreset === 1'b1);

        repeat (5) cycle(1'b0, '0);
        finish_test("reset");

        for (int i = 0; i < 300; i++) begin
            cycle(1'b1, random_alu());
            repeat ($urandom_range(3, 0)) cycle(1'b0, random_alu());
        end
        cycle(1'b0, '0);
        finish_test("latency");

        repeat (200) cycle(1'b1, random_alu());
        cycle(1'b0, '0);
        finish_test("back_to_back");

        for (int i = 0; i < 200; i++) begin
            repeat ($urandom_range(2, 0)) cycle(1'b1, random_alu());
            cycle(1'b1, random_branch());
        end
        cycle(1'b0, '0);
        finish_test("branches");

        repeat (50) cycle(1'b0, random_alu());
        cycle(1'b0, '0);
        finish_test("idle");

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #(timeout_time);
        $display("timeout: the tests did not finish within %0d time units", timeout_time);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
hw/tiny16_pkg.sv
hw/tiny16_alu.sv
hw/tiny16_branch.sv
hw/tiny16_commit.sv
hw/tiny16_exec.sv
verif/tb_clock.sv
verif/tiny16_exec_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tiny16_exec_tb -f flist.f -o tiny16_exec_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/tiny16_exec_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1
